// ==== hw/rvv_dispatch_config.svh ====
// ---------------------------------------------------------------------
// Widths and counts of the vector dispatch stage.
// Included by the package and by every module that sizes ports.
// ---------------------------------------------------------------------

`ifndef RVV_DISPATCH_CONFIG_SVH
`define RVV_DISPATCH_CONFIG_SVH

// uops handed over by decode per cycle
// the hazard rules only cover a pair
`define NUM_DP_UOP 2

// VRF read ports, two per uop
`define NUM_DP_VRF 4

// vector register index
`define REGFILE_INDEX_WIDTH 5

// data width of one vector register in this model
`define VLEN 32

// uop identifier carried through to the reservation stations
`define UOP_TAG_WIDTH 4

`endif

// ==== hw/rvv_dispatch_pkg.sv ====
// ---------------------------------------------------------------------
// Types shared by the dispatch stage: register vectors, uop classes,
// execution units, the uop record and the issue record.
// ---------------------------------------------------------------------

`include "rvv_dispatch_config.svh"

package rvv_dispatch_pkg;

    typedef logic [`REGFILE_INDEX_WIDTH-1:0] vreg_index_t;
    typedef logic [`VLEN-1:0]                vreg_data_t;
    typedef logic [`UOP_TAG_WIDTH-1:0]       uop_tag_t;

    // number of vector sources read by a uop
    typedef enum logic [1:0] {
        VVV = 2'd0,  // vs2, vs1 and vd
        VV  = 2'd1,  // two sources
        VX  = 2'd2,  // one vector source
        X   = 2'd3   // no vector source
    } uop_class_e;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MAC = 2'd1,
        LSU = 2'd2,
        PMT = 2'd3
    } exe_unit_e;

    typedef struct packed {
        logic        valid;
        uop_tag_t    tag;
        uop_class_e  uop_class;
        exe_unit_e   exe_unit;
        vreg_index_t vs1_index;
        vreg_index_t vs2_index;
        vreg_index_t vd_index;
        logic        vs2_valid;
        // vd is read as a third source
        logic        vs3_valid;
    } strct_uop_t;

    typedef struct packed {
        logic vr_limit;
        logic pu_limit;
    } arch_hazard_t;

    // one record handed to the reservation stations
    typedef struct packed {
        strct_uop_t  [`NUM_DP_UOP-1:0] uop;
        vreg_index_t [`NUM_DP_VRF-1:0] rd_index;
        vreg_data_t  [`NUM_DP_VRF-1:0] rd_data;
    } dp_issue_t;

endpackage

// ==== hw/rvv_dispatch_structure_hazard.sv ====
// ---------------------------------------------------------------------
// Maps a uop pair onto the four VRF read ports and flags the structure
// hazards that force the pair to split. Purely combinational.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

`include "rvv_dispatch_config.svh"

module rvv_dispatch_structure_hazard (
    input  rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] strct_uop,
    output rvv_dispatch_pkg::vreg_index_t [`NUM_DP_VRF-1:0] rd_index,
    output rvv_dispatch_pkg::arch_hazard_t                  arch_hazard
);

    // an empty slot behaves as class X without a vd read
    rvv_dispatch_pkg::uop_class_e [`NUM_DP_UOP-1:0] eff_class;
    logic [`NUM_DP_UOP-1:0] vd_rd;
    logic                   both_valid;

    always_comb begin
        for (int k = 0; k < `NUM_DP_UOP; k++) begin
            eff_class[k] = strct_uop[k].valid ? strct_uop[k].uop_class
                                              : rvv_dispatch_pkg::X;
            vd_rd[k]     = strct_uop[k].valid & strct_uop[k].vs3_valid;
        end
    end

    assign both_valid = strct_uop[0].valid & strct_uop[1].valid;

    // port 2i  : vs2 or vs1 of uop i
    // port 2i+1: vs1 / vd of uop i, or the mate's vd
    always_comb begin
        int m;
        rd_index = '0;
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            m = i ^ 1;
            case (eff_class[i])
                rvv_dispatch_pkg::VVV: begin
                    rd_index[2*i] = strct_uop[i].vs2_index;
                    if (i[0] && vd_rd[m]) begin
                        rd_index[2*i+1] = strct_uop[m].vd_index;
                    end else begin
                        rd_index[2*i+1] = strct_uop[i].vs1_index;
                    end
                end
                rvv_dispatch_pkg::VV: begin
                    rd_index[2*i] = strct_uop[i].vs2_index;
                    // odd slot gives way to a VVV mate
                    if (i[0] && eff_class[m] == rvv_dispatch_pkg::VVV) begin
                        rd_index[2*i+1] = strct_uop[m].vd_index;
                    end else if (strct_uop[i].vs3_valid) begin
                        rd_index[2*i+1] = strct_uop[i].vd_index;
                    end else begin
                        rd_index[2*i+1] = strct_uop[i].vs1_index;
                    end
                end
                rvv_dispatch_pkg::VX: begin
                    // vmv style uops only carry vs1
                    rd_index[2*i] = strct_uop[i].vs2_valid ? strct_uop[i].vs2_index
                                                           : strct_uop[i].vs1_index;
                    if (vd_rd[m]) begin
                        rd_index[2*i+1] = strct_uop[m].vd_index;
                    end
                end
                default: begin
                    // class X leaves its own port unused
                    if (vd_rd[m]) begin
                        rd_index[2*i+1] = strct_uop[m].vd_index;
                    end
                end
            endcase
        end
    end

    // more than four vector reads in the pair
    always_comb begin
        arch_hazard.vr_limit = 1'b0;
        if (both_valid) begin
            if ((eff_class[0] == rvv_dispatch_pkg::VVV &&
                 eff_class[1] == rvv_dispatch_pkg::VVV) ||
                (eff_class[0] == rvv_dispatch_pkg::VVV &&
                 eff_class[1] == rvv_dispatch_pkg::VV) ||
                (eff_class[0] == rvv_dispatch_pkg::VV &&
                 eff_class[1] == rvv_dispatch_pkg::VVV)) begin
                arch_hazard.vr_limit = 1'b1;
            end
        end
    end

    // only one MAC unit
    always_comb begin
        arch_hazard.pu_limit = both_valid &&
                               strct_uop[0].exe_unit == rvv_dispatch_pkg::MAC &&
                               strct_uop[1].exe_unit == rvv_dispatch_pkg::MAC;
    end

endmodule

// ==== hw/rvv_dispatch_ctrl.sv ====
// ---------------------------------------------------------------------
// Dispatch control. Holds the uop pair taken from decode, issues it
// whole or splits it on a structure hazard, and keeps the issue record
// stable while the reservation stations apply back-pressure.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

`include "rvv_dispatch_config.svh"

module rvv_dispatch_ctrl (
    input  logic                                            clk,
    input  logic                                            rst_n,

    // decode side
    input  logic                                            uop_valid,
    input  rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] uop_pair,
    output logic                                            uop_ready,

    // hazard check and VRF
    output rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] hold_pair,
    input  rvv_dispatch_pkg::arch_hazard_t                  arch_hazard,
    input  rvv_dispatch_pkg::vreg_index_t [`NUM_DP_VRF-1:0] rd_index,
    input  rvv_dispatch_pkg::vreg_data_t  [`NUM_DP_VRF-1:0] rd_data,

    // reservation station side
    output logic                                            dp_valid,
    output rvv_dispatch_pkg::dp_issue_t                     dp_issue,
    input  logic                                            rs_ready
);

    logic hold_busy;
    logic out_free;
    logic split;
    logic issue_now;
    logic issue_all;
    logic accept;

    rvv_dispatch_pkg::strct_uop_t [`NUM_DP_UOP-1:0] issue_slots;

    assign hold_busy = hold_pair[0].valid | hold_pair[1].valid;

    // output register empty or being drained this edge
    assign out_free  = ~dp_valid | rs_ready;

    assign split     = arch_hazard.vr_limit | arch_hazard.pu_limit;
    assign issue_now = hold_busy & out_free;
    assign issue_all = issue_now & ~split;

    // a new pair may land in the same edge the held pair leaves
    assign uop_ready = ~hold_busy | issue_all;
    assign accept    = uop_valid & uop_ready;

    // on a split only uop0 goes out, slot 1 of the record is empty
    always_comb begin
        issue_slots = hold_pair;
        if (split) begin
            issue_slots[1] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_pair <= '0;
        end else if (accept) begin
            hold_pair <= uop_pair;
        end else if (issue_now && split) begin
            // uop1 moves down and is rechecked on its own
            hold_pair[0] <= hold_pair[1];
            hold_pair[1] <= '0;
        end else if (issue_all) begin
            hold_pair <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
        end else if (issue_now) begin
            dp_valid <= 1'b1;
        end else if (rs_ready) begin
            dp_valid <= 1'b0;
        end
    end

    // record payload, only loaded when something issues
    always_ff @(posedge clk) begin
        if (issue_now) begin
            dp_issue.uop      <= issue_slots;
            dp_issue.rd_index <= rd_index;
            dp_issue.rd_data  <= rd_data;
        end
    end

endmodule

// ==== hw/rvv_vrf.sv ====
// ---------------------------------------------------------------------
// Vector register file model with one write port from writeback and
// four combinational read ports for dispatch.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

`include "rvv_dispatch_config.svh"

module rvv_vrf (
    input  logic                                            clk,
    input  logic                                            rst_n,

    // writeback port
    input  logic                                            wr_en,
    input  rvv_dispatch_pkg::vreg_index_t                   wr_index,
    input  rvv_dispatch_pkg::vreg_data_t                    wr_data,

    // dispatch read ports
    input  rvv_dispatch_pkg::vreg_index_t [`NUM_DP_VRF-1:0] rd_index,
    output rvv_dispatch_pkg::vreg_data_t  [`NUM_DP_VRF-1:0] rd_data
);

    localparam int NUM_REGS = 1 << `REGFILE_INDEX_WIDTH;

    rvv_dispatch_pkg::vreg_data_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_index] <= wr_data;
        end
    end

    // no write bypass, a read sees the value before the edge
    always_comb begin
        for (int p = 0; p < `NUM_DP_VRF; p++) begin
            rd_data[p] = regs[rd_index[p]];
        end
    end

endmodule

// ==== hw/rvv_dispatch_top.sv ====
// ---------------------------------------------------------------------
// Dispatch stage top. Takes uop pairs from decode, reads operands from
// the VRF and hands issue records to the reservation stations.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

`include "rvv_dispatch_config.svh"

module rvv_dispatch_top (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  logic                                           uop_valid,
    input  rvv_dispatch_pkg::strct_uop_t [`NUM_DP_UOP-1:0] uop_pair,
    output logic                                           uop_ready,

    output logic                                           dp_valid,
    output rvv_dispatch_pkg::dp_issue_t                    dp_issue,
    input  logic                                           rs_ready,

    input  logic                                           vrf_wr_en,
    input  rvv_dispatch_pkg::vreg_index_t                  vrf_wr_index,
    input  rvv_dispatch_pkg::vreg_data_t                   vrf_wr_data
);

    rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] hold_pair;
    rvv_dispatch_pkg::vreg_index_t [`NUM_DP_VRF-1:0] rd_index;
    rvv_dispatch_pkg::vreg_data_t  [`NUM_DP_VRF-1:0] rd_data;
    rvv_dispatch_pkg::arch_hazard_t                  arch_hazard;

    rvv_dispatch_ctrl rvv_dispatch_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop_valid   (uop_valid),
        .uop_pair    (uop_pair),
        .uop_ready   (uop_ready),
        .hold_pair   (hold_pair),
        .arch_hazard (arch_hazard),
        .rd_index    (rd_index),
        .rd_data     (rd_data),
        .dp_valid    (dp_valid),
        .dp_issue    (dp_issue),
        .rs_ready    (rs_ready)
    );

    // hazard check sees the held pair, not the incoming one
    rvv_dispatch_structure_hazard rvv_dispatch_structure_hazard_i (
        .strct_uop   (hold_pair),
        .rd_index    (rd_index),
        .arch_hazard (arch_hazard)
    );

    rvv_vrf rvv_vrf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (vrf_wr_en),
        .wr_index (vrf_wr_index),
        .wr_data  (vrf_wr_data),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
// ---------------------------------------------------------------------
// Free running testbench clock, 40 ns period.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

endmodule

// ==== dv/rvv_dispatch_checker.sv ====
// ---------------------------------------------------------------------
// Watches the reservation station side of the dispatch stage and
// compares every accepted issue record with the expected queue.
// The testbench fills the queue through expect_record.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dp_valid,
    input  rvv_dispatch_pkg::dp_issue_t dp_issue,
    input  logic                        rs_ready,
    output int                          errors,
    output int                          checks
);

    rvv_dispatch_pkg::dp_issue_t exp_q [$];
    string                       name_q [$];
    int                          err_cnt = 0;
    int                          chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task expect_record(input string name, input rvv_dispatch_pkg::dp_issue_t rec);
        exp_q.push_back(rec);
        name_q.push_back(name);
    endtask

    function int pending_count();
        return exp_q.size();
    endfunction

    always @(posedge clk) begin
        rvv_dispatch_pkg::dp_issue_t exp_rec;
        string                       name;
        if (rst_n && dp_valid && rs_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: issue record with slot0 tag %h arrived, none was expected",
                         dp_issue.uop[0].tag);
                err_cnt++;
            end else begin
                exp_rec = exp_q.pop_front();
                name    = name_q.pop_front();
                chk_cnt++;
                if (dp_issue.uop !== exp_rec.uop) begin
                    $display("CHECK FAILED test=%s uops expected=%h actual=%h",
                             name, exp_rec.uop, dp_issue.uop);
                    err_cnt++;
                end
                if (dp_issue.rd_index !== exp_rec.rd_index) begin
                    $display("CHECK FAILED test=%s rd_index expected=%h actual=%h",
                             name, exp_rec.rd_index, dp_issue.rd_index);
                    err_cnt++;
                end
                if (dp_issue.rd_data !== exp_rec.rd_data) begin
                    $display("CHECK FAILED test=%s rd_data expected=%h actual=%h",
                             name, exp_rec.rd_data, dp_issue.rd_data);
                    err_cnt++;
                end
            end
        end
    end

endmodule

// ==== dv/rvv_dispatch_assert.sv ====
// ---------------------------------------------------------------------
// Concurrent checks on the dispatch top, attached with bind.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        dp_valid,
    input logic                        rs_ready,
    input rvv_dispatch_pkg::dp_issue_t dp_issue
);

    logic both_slots;
    logic vr_pair;
    logic mac_pair;

    assign both_slots = dp_issue.uop[0].valid & dp_issue.uop[1].valid;

    // more than four vector reads between the two slots
    assign vr_pair = (dp_issue.uop[0].uop_class inside {rvv_dispatch_pkg::VVV,
                                                         rvv_dispatch_pkg::VV}) &&
                     (dp_issue.uop[1].uop_class inside {rvv_dispatch_pkg::VVV,
                                                         rvv_dispatch_pkg::VV}) &&
                     (dp_issue.uop[0].uop_class == rvv_dispatch_pkg::VVV ||
                      dp_issue.uop[1].uop_class == rvv_dispatch_pkg::VVV);

    // single MAC unit
    assign mac_pair = dp_issue.uop[0].exe_unit == rvv_dispatch_pkg::MAC &&
                      dp_issue.uop[1].exe_unit == rvv_dispatch_pkg::MAC;

    a_stable_bp: assert property (@(posedge clk) disable iff (!rst_n)
        dp_valid && !rs_ready |=> dp_valid && $stable(dp_issue))
        else $error("dp_issue changed while the reservation station held it off");

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !dp_valid)
        else $error("dp_valid high right after reset");

    a_split_slot1: assert property (@(posedge clk) disable iff (!rst_n)
        dp_valid && both_slots |-> !vr_pair && !mac_pair)
        else $error("hazard pair issued both uops in one record");

endmodule

bind rvv_dispatch_top rvv_dispatch_assert rvv_dispatch_assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .dp_valid (dp_valid),
    .rs_ready (rs_ready),
    .dp_issue (dp_issue)
);

// ==== dv/rvv_dispatch_tb.sv ====
// ---------------------------------------------------------------------
// Testbench top for the dispatch stage. Preloads the VRF, replays the
// tests file into the DUT and pushes the expected issue records.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

`include "rvv_dispatch_config.svh"

module rvv_dispatch_tb;

    localparam int TIMEOUT = 400;

    logic                                            clk;
    logic                                            rst_n;
    logic                                            uop_valid;
    rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] uop_pair;
    logic                                            uop_ready;
    logic                                            dp_valid;
    rvv_dispatch_pkg::dp_issue_t                     dp_issue;
    logic                                            rs_ready;
    logic                                            vrf_wr_en;
    rvv_dispatch_pkg::vreg_index_t                   vrf_wr_index;
    rvv_dispatch_pkg::vreg_data_t                    vrf_wr_data;

    int     chk_errors;
    int     chk_checks;
    int     tb_errors;
    int     fd;
    integer seed;
    logic   rand_bp;
    logic   failed;
    string  tok;
    string  rest;
    int     wr_idx;
    int     wr_val;
    int     rc;

    // copy of the VRF contents for expected read data
    rvv_dispatch_pkg::vreg_data_t vrf_model [32];

    tb_clock_gen tb_clock_gen_i (.clk(clk));

    rvv_dispatch_top rvv_dispatch_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop_pair     (uop_pair),
        .uop_ready    (uop_ready),
        .dp_valid     (dp_valid),
        .dp_issue     (dp_issue),
        .rs_ready     (rs_ready),
        .vrf_wr_en    (vrf_wr_en),
        .vrf_wr_index (vrf_wr_index),
        .vrf_wr_data  (vrf_wr_data)
    );

    rvv_dispatch_checker rvv_dispatch_checker_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dp_valid (dp_valid),
        .dp_issue (dp_issue),
        .rs_ready (rs_ready),
        .errors   (chk_errors),
        .checks   (chk_checks)
    );

    // register n gets a value that carries n
    function rvv_dispatch_pkg::vreg_data_t fill_value(input int idx);
        return {16'hC0DE, 3'b000, idx[4:0], 3'b101, ~idx[4:0]};
    endfunction

    function rvv_dispatch_pkg::strct_uop_t uop_by_tag(
        input rvv_dispatch_pkg::strct_uop_t [`NUM_DP_UOP-1:0] pair,
        input int tag
    );
        for (int k = 0; k < `NUM_DP_UOP; k++) begin
            if (pair[k].valid && pair[k].tag == rvv_dispatch_pkg::uop_tag_t'(tag)) begin
                return pair[k];
            end
        end
        return '0;
    endfunction

    // random back-pressure from the reservation stations
    always @(posedge clk) begin
        if (!rst_n || !rand_bp) begin
            rs_ready <= 1'b1;
        end else begin
            rs_ready <= ($random(seed) & 3) != 0;
        end
    end

    task write_vrf(input int idx, input rvv_dispatch_pkg::vreg_data_t data);
        @(posedge clk);
        vrf_wr_en    <= 1'b1;
        vrf_wr_index <= rvv_dispatch_pkg::vreg_index_t'(idx);
        vrf_wr_data  <= data;
        @(posedge clk);
        vrf_wr_en    <= 1'b0;
        vrf_model[idx[4:0]] = data;
    endtask

    task send_pair(input rvv_dispatch_pkg::strct_uop_t [`NUM_DP_UOP-1:0] pair);
        int   cnt;
        logic rdy;
        cnt = 0;
        @(posedge clk);
        uop_valid <= 1'b1;
        uop_pair  <= pair;
        forever begin
            @(negedge clk);
            rdy = uop_ready;
            @(posedge clk);
            if (rdy) begin
                break;
            end
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("timeout: DUT never accepted the uop pair");
                failed = 1'b1;
                break;
            end
        end
        uop_valid <= 1'b0;
    endtask

    // all expected records consumed
    task wait_drain();
        int cnt;
        cnt = 0;
        while (rvv_dispatch_checker_i.pending_count() != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("timeout: expected issue records never arrived");
                failed = 1'b1;
                break;
            end
        end
    endtask

    task run_pair_line();
        string                                           name;
        int                                              f [9];
        int                                              e [8];
        int                                              nrec;
        int                                              cnt;
        rvv_dispatch_pkg::strct_uop_t  [`NUM_DP_UOP-1:0] pair;
        rvv_dispatch_pkg::dp_issue_t                     rec;
        cnt = $fscanf(fd, "%s", name);
        for (int u = 0; u < `NUM_DP_UOP; u++) begin
            cnt += $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            pair[u].valid     = f[0][0];
            pair[u].tag       = rvv_dispatch_pkg::uop_tag_t'(f[1]);
            pair[u].uop_class = rvv_dispatch_pkg::uop_class_e'(f[2][1:0]);
            pair[u].exe_unit  = rvv_dispatch_pkg::exe_unit_e'(f[3][1:0]);
            pair[u].vs1_index = rvv_dispatch_pkg::vreg_index_t'(f[4]);
            pair[u].vs2_index = rvv_dispatch_pkg::vreg_index_t'(f[5]);
            pair[u].vd_index  = rvv_dispatch_pkg::vreg_index_t'(f[6]);
            pair[u].vs2_valid = f[7][0];
            pair[u].vs3_valid = f[8][0];
        end
        cnt += $fscanf(fd, "%d", nrec);
        if (cnt != 20 || nrec < 1 || nrec > 2) begin
            $display("malformed pair line in the tests file near %s", name);
            failed = 1'b1;
            return;
        end
        for (int r = 0; r < nrec; r++) begin
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                          e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]);
            if (cnt != 8) begin
                $display("malformed expected record in test %s", name);
                failed = 1'b1;
                return;
            end
            rec.uop[0] = e[0][0] ? uop_by_tag(pair, e[1]) : '0;
            rec.uop[1] = e[2][0] ? uop_by_tag(pair, e[3]) : '0;
            for (int p = 0; p < `NUM_DP_VRF; p++) begin
                rec.rd_index[p] = rvv_dispatch_pkg::vreg_index_t'(e[4+p]);
                rec.rd_data[p]  = vrf_model[e[4+p][4:0]];
            end
            rvv_dispatch_checker_i.expect_record(name, rec);
        end
        send_pair(pair);
    endtask

    initial begin
        seed         = 32'h615;
        rand_bp      = 1'b0;
        failed       = 1'b0;
        tb_errors    = 0;
        rst_n        = 1'b0;
        uop_valid    = 1'b0;
        uop_pair     = '0;
        rs_ready     = 1'b1;
        vrf_wr_en    = 1'b0;
        vrf_wr_index = '0;
        vrf_wr_data  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < 32; n++) begin
            write_vrf(n, fill_value(n));
        end
        rand_bp <= 1'b1;
        fd = $fopen("dv/dispatch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/dispatch_tests.txt");
            failed = 1'b1;
        end
        while (!failed && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(rest, fd);
            end else if (tok == "W") begin
                rc = $fscanf(fd, "%h %h", wr_idx, wr_val);
                wait_drain();
                write_vrf(wr_idx, rvv_dispatch_pkg::vreg_data_t'(wr_val));
            end else if (tok == "P") begin
                run_pair_line();
            end else begin
                $display("unknown line kind %s in the tests file", tok);
                failed = 1'b1;
            end
        end
        wait_drain();
        if (failed) begin
            tb_errors++;
        end
        repeat (2) @(posedge clk);
        $display("checks=%0d check_errors=%0d testbench_errors=%0d",
                 chk_checks, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0 && chk_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/dispatch_tests.txt ====
# W: vrf index, data (hex). P: name, uop0 and uop1 as valid tag class unit vs1 vs2 vd vs2v vs3v,
# record count, then per record v0 tag0 v1 tag1 idx0 idx1 idx2 idx3 (class 0..3 VVV VV VX X)
# vvv and vx issue together, mate vd on port 3
P vvv_vx     1 1 0 0 01 02 03 1 1   1 2 2 0 04 05 06 1 0   1   1 1 1 2 02 01 05 03
# vr_limit split
P vvv_vv     1 3 0 1 07 08 09 1 1   1 4 1 0 0a 0b 0c 1 0   2   1 3 0 0 08 07 0b 09   1 4 0 0 0b 0a 00 00
# pu_limit split
P mac_mac    1 5 1 1 01 02 03 1 1   1 6 2 1 04 05 06 0 0   2   1 5 0 0 02 03 04 03   1 6 0 0 04 00 00 00
# one mac, no split
P mac_alu    1 7 1 1 0d 0e 0f 1 0   1 8 1 0 10 11 12 1 0   1   1 7 1 8 0e 0d 11 10
# port sharing cases
P vx_share   1 9 2 0 14 15 16 1 0   1 a 1 2 17 18 19 1 1   1   1 9 1 a 15 19 18 19
P x_no_vd    1 b 3 3 1a 1b 1c 0 0   1 c 2 0 1d 1e 1f 1 0   1   1 b 1 c 00 00 1e 00
P x_mate_vd  1 d 0 0 01 02 04 1 1   1 e 3 0 01 05 06 0 0   1   1 d 1 e 02 01 00 04
P vvv_vvv    1 f 0 0 03 05 07 1 1   1 0 0 0 09 0b 0d 1 1   2   1 f 0 0 05 03 0b 07   1 0 0 0 0b 09 00 0d
# write then read
W 0b 12345678
P vrf_write  1 1 1 0 0b 0c 00 1 0   1 2 2 2 0b 00 00 0 0   1   1 1 1 2 0c 0b 0b 00

// ==== all.f ====
+incdir+hw
hw/rvv_dispatch_pkg.sv
hw/rvv_dispatch_structure_hazard.sv
hw/rvv_dispatch_ctrl.sv
hw/rvv_vrf.sv
hw/rvv_dispatch_top.sv
dv/tb_clock_gen.sv
dv/rvv_dispatch_checker.sv
dv/rvv_dispatch_assert.sv
dv/rvv_dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module rvv_dispatch_tb -o rvv_dispatch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/rvv_dispatch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "no verdict found in sim.log"
    exit 1
fi
exit 0
